/* common/regs_params.svh */
// register file constants
// bank count, special bank codes, stack reset value and the
// address map of the debug dump port
`ifndef REGS_PARAMS_SVH
`define REGS_PARAMS_SVH

// banks of sixteen bytes each
`define REGS_BANKS 4

// bank fields with a special meaning
`define REGS_CODE_CUR  4'he
`define REGS_CODE_PREV 4'hd
`define REGS_CODE_ZERO 4'h4

// stack pointer after reset
`define REGS_XSP_RESET 32'h100

// dump map, banks below the pointer area
`define REGS_DMP_PTR_BASE 8'h40
`define REGS_DMP_PTR_LAST 8'h4f
`define REGS_DMP_SR_HI    8'h50
`define REGS_DMP_SR_LO    8'h51

`endif

/* common/regs_pkg.sv */
// register file types
// one register code byte, seen either as a bank/index pair
// or as a pointer register selector with a byte lane
package regs_pkg;

    // general bank area
    // bank field 0..3 is absolute, current and previous are
    // resolved by the code mapper
    typedef struct packed {
        logic [3:0] bank;
        logic [3:0] idx;
    } reg_bank_view_t;

    // pointer area, XIX XIY XIZ XSP
    typedef struct packed {
        logic       flag;
        logic [2:0] unused;
        logic [1:0] num;
        logic [1:0] lane;
    } reg_ptr_view_t;

    // the same eight bits decoded both ways
    typedef union packed {
        reg_bank_view_t bank;
        reg_ptr_view_t  ptr;
    } reg_code_t;

endpackage

/* regs/reg_code_map.sv */
// register code mapper
// holds the register file pointer and turns current-bank and
// previous-bank codes of both read ports into absolute codes
`timescale 1ns/1ns
`include "regs_params.svh"

module reg_code_map import regs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       inc_rfp,
    input  logic       dec_rfp,
    input  logic       rfp_we,
    input  logic [1:0] imm,
    input  reg_code_t  src,
    input  reg_code_t  dst,
    output logic [1:0] rfp,
    output reg_code_t  src_abs,
    output reg_code_t  dst_abs
);

    logic [1:0] prev_bank;

    // previous bank wraps from 0 to 3
    assign prev_bank = rfp - 2'd1;

    function automatic reg_code_t resolve(
        input reg_code_t  code,
        input logic [1:0] cur,
        input logic [1:0] prev
    );
        reg_code_t res;
        res = code;
        if (code.bank.bank == `REGS_CODE_CUR) begin
            res.bank.bank = {2'b00, cur};
        end else if (code.bank.bank == `REGS_CODE_PREV) begin
            res.bank.bank = {2'b00, prev};
        end
        // byte index is never touched
        return res;
    endfunction

    always_comb begin
        src_abs = resolve(src, rfp, prev_bank);
        dst_abs = resolve(dst, rfp, prev_bank);
    end

    // load beats decrement, decrement beats increment
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp <= 2'd0;
        end else if (cen) begin
            if (rfp_we) begin
                rfp <= imm;
            end else if (dec_rfp) begin
                rfp <= rfp - 2'd1;
            end else if (inc_rfp) begin
                rfp <= rfp + 2'd1;
            end
        end
    end

endmodule

/* regs/reg_file.sv */
// general register storage
// four banks of sixteen bytes plus the shared pointer registers,
// with two combinational read ports, ALU/RAM writes, source
// register stepping, stack adjust, BC decrement and a registered
// debug dump port that also returns the status register
`timescale 1ns/1ns
`include "regs_params.svh"

module reg_file import regs_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [ 1:0] rfp,
    input  reg_code_t   src_abs,
    input  reg_code_t   dst_abs,
    input  logic [31:0] alu_dout,
    input  logic [31:0] ram_dout,
    input  logic        data_sel,
    input  logic [ 2:0] alu_we,
    input  logic [ 2:0] ram_we,
    input  logic        flag_only,
    input  logic        reg_inc,
    input  logic        reg_dec,
    input  logic [ 1:0] reg_step,
    input  logic [15:0] inc_xsp,
    input  logic [15:0] dec_xsp,
    input  logic        dec_bc,
    input  logic [15:0] sr,
    input  logic [ 7:0] dmp_addr,
    output logic [31:0] src_out,
    output logic [31:0] dst_out,
    output logic [31:0] xsp,
    output logic        bc_unity,
    output logic [ 7:0] dmp_dout
);

    localparam int NBYTES = `REGS_BANKS * 16;

    logic [7:0] bank_q [0:NBYTES-1];
    logic [7:0] ptr_q  [0:15];

    logic [31:0]      din;
    logic [ 2:0]      we;
    logic [ 3:0]      lane_we;
    logic [ 3:0][7:0] lane_data;
    logic [31:0]      full_step;
    logic [31:0]      step_long;
    logic             src_zero;
    logic [15:0]      cur_bc;

    // aligned long word addressed by a code
    function automatic logic [31:0] read_long(input reg_code_t code);
        logic [31:0] val;
        for (int i = 0; i < 4; i++) begin
            if (code.ptr.flag) begin
                val[8*i +: 8] = ptr_q[{code.ptr.num, 2'(i)}];
            end else begin
                val[8*i +: 8] = bank_q[{code.bank.bank[1:0], code.bank.idx[3:2], 2'(i)}];
            end
        end
        return val;
    endfunction

    assign src_zero = src_abs.bank.bank == `REGS_CODE_ZERO;

    always_comb begin
        src_out = src_zero ? 32'd0 : read_long(src_abs);
        dst_out = read_long(dst_abs);
    end

    assign xsp    = {ptr_q[15], ptr_q[14], ptr_q[13], ptr_q[12]};
    assign cur_bc = {bank_q[{rfp, 4'd5}], bank_q[{rfp, 4'd4}]};

    // write source and width
    assign din = data_sel ? ram_dout : alu_dout;
    assign we  = flag_only ? 3'd0 : (data_sel ? ram_we : alu_we);

    // lanes of the aligned long touched by the write
    always_comb begin
        lane_we   = 4'd0;
        lane_data = din;
        if (we[0]) begin
            lane_we[dst_abs.ptr.lane]   = 1'b1;
            lane_data[dst_abs.ptr.lane] = din[7:0];
        end
        if (we[1]) begin
            lane_we[{dst_abs.ptr.lane[1], 1'b0}]   = 1'b1;
            lane_we[{dst_abs.ptr.lane[1], 1'b1}]   = 1'b1;
            lane_data[{dst_abs.ptr.lane[1], 1'b0}] = din[7:0];
            lane_data[{dst_abs.ptr.lane[1], 1'b1}] = din[15:8];
        end
        if (we[2]) begin
            lane_we   = 4'hf;
            lane_data = din;
        end
    end

    // step of 1, 2 or 4 on the source long
    assign full_step = reg_step == 2'd1 ? 32'd2 :
                       reg_step == 2'd2 ? 32'd4 : 32'd1;
    assign step_long = reg_dec ? src_out - full_step : src_out + full_step;

    // later assignments win: step, BC, stack, then the write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NBYTES; i++) begin
                bank_q[i] <= 8'd0;
            end
            for (int i = 0; i < 16; i++) begin
                ptr_q[i] <= 8'd0;
            end
            {ptr_q[15], ptr_q[14], ptr_q[13], ptr_q[12]} <= `REGS_XSP_RESET;
            bc_unity <= 1'b0;
        end else if (cen) begin
            bc_unity <= cur_bc == 16'd1;

            if ((reg_inc || reg_dec) && !src_zero) begin
                for (int i = 0; i < 4; i++) begin
                    if (src_abs.ptr.flag) begin
                        ptr_q[{src_abs.ptr.num, 2'(i)}] <= step_long[8*i +: 8];
                    end else begin
                        bank_q[{src_abs.bank.bank[1:0], src_abs.bank.idx[3:2], 2'(i)}]
                            <= step_long[8*i +: 8];
                    end
                end
            end

            if (dec_bc) begin
                {bank_q[{rfp, 4'd5}], bank_q[{rfp, 4'd4}]} <= cur_bc - 16'd1;
            end

            // increment has priority over decrement
            if (inc_xsp != 16'd0) begin
                {ptr_q[15], ptr_q[14], ptr_q[13], ptr_q[12]} <= xsp + {16'd0, inc_xsp};
            end else if (dec_xsp != 16'd0) begin
                {ptr_q[15], ptr_q[14], ptr_q[13], ptr_q[12]} <= xsp - {16'd0, dec_xsp};
            end

            for (int i = 0; i < 4; i++) begin
                if (lane_we[i]) begin
                    if (dst_abs.ptr.flag) begin
                        ptr_q[{dst_abs.ptr.num, 2'(i)}] <= lane_data[i];
                    end else begin
                        bank_q[{dst_abs.bank.bank[1:0], dst_abs.bank.idx[3:2], 2'(i)}]
                            <= lane_data[i];
                    end
                end
            end
        end
    end

    // debug dump, runs even with cen low
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dmp_dout <= 8'd0;
        end else begin
            if (dmp_addr < `REGS_DMP_PTR_BASE) begin
                dmp_dout <= bank_q[dmp_addr[5:0]];
            end else if (dmp_addr <= `REGS_DMP_PTR_LAST) begin
                dmp_dout <= ptr_q[dmp_addr[3:0]];
            end else if (dmp_addr == `REGS_DMP_SR_HI) begin
                dmp_dout <= sr[15:8];
            end else if (dmp_addr == `REGS_DMP_SR_LO) begin
                dmp_dout <= sr[7:0];
            end else begin
                dmp_dout <= 8'd0;
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module regs_tb \
    -Mdir obj_dir -o regs_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/regs_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

/* test/regs_props.sv */
// register file properties
// reset behavior of bc_unity, bank pointer freeze and
// flag-only cycles, checked on the top level through bind
`timescale 1ns/1ns

module regs_props (
    input logic        clk,
    input logic        rst,
    input logic        cen,
    input logic [ 1:0] rfp,
    input logic        bc_unity,
    input logic        flag_only,
    input logic [ 7:0] dst,
    input logic [31:0] dst_out,
    input logic        reg_inc,
    input logic        reg_dec,
    input logic [15:0] inc_xsp,
    input logic [15:0] dec_xsp,
    input logic        dec_bc
);

    logic quiet_flag_cycle;

    assign quiet_flag_cycle = cen && flag_only && !reg_inc && !reg_dec && !dec_bc
                              && inc_xsp == 16'd0 && dec_xsp == 16'd0;

    // first two cycles after reset
    bc_first: assert property (@(posedge clk) ($past(rst) && !rst) |-> !bc_unity)
        else $error("bc_unity high right after reset");
    bc_second: assert property (@(posedge clk)
        ($past(rst, 2) && !$past(rst) && !rst) |-> !bc_unity)
        else $error("bc_unity high in the second cycle after reset");

    rfp_frozen: assert property (@(posedge clk) disable iff (rst)
        $past(!cen) |-> $stable(rfp))
        else $error("rfp changed while cen was low");

    flag_no_write: assert property (@(posedge clk) disable iff (rst)
        ($past(quiet_flag_cycle) && $stable(dst) && $stable(rfp)) |-> $stable(dst_out))
        else $error("flag-only cycle changed the destination register");

endmodule

bind regs_top regs_props props_inst (
    .clk       (clk),
    .rst       (rst),
    .cen       (cen),
    .rfp       (rfp),
    .bc_unity  (bc_unity),
    .flag_only (flag_only),
    .dst       (dst),
    .dst_out   (dst_out),
    .reg_inc   (reg_inc),
    .reg_dec   (reg_dec),
    .inc_xsp   (inc_xsp),
    .dec_xsp   (dec_xsp),
    .dec_bc    (dec_bc)
);

/* test/regs_tb.sv */
// register file testbench
// random writes, bank switching, steps, stack and BC checks against
// a byte model, with a comparing process on every falling edge
`timescale 1ns/1ns
`include "regs_params.svh"

module regs_tb import regs_pkg::*;;

    logic clk, rst, cen, inc_rfp, dec_rfp, rfp_we, data_sel, flag_only;
    logic reg_inc, reg_dec, dec_bc, bc_unity;
    logic [1:0] imm, reg_step, rfp;
    logic [7:0] src, dst, dmp_addr, dmp_dout;
    logic [2:0] alu_we, ram_we;
    logic [15:0] inc_xsp, dec_xsp, sr;
    logic [31:0] alu_dout, ram_dout, src_out, dst_out, xsp;

    // bytes 0..63 are the banks, 64..79 the pointers, as in the dump map
    logic [7:0] model_mem [0:79];
    logic [1:0] model_rfp;
    logic [7:0] exp_dmp;
    logic       exp_bcu;
    integer     seed;
    int         err_count;

    regs_top regs_top_inst (.*);

    always #50 clk = ~clk;

    task automatic stop_with_fail();
        err_count++;
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        stop_with_fail();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_fail();
        end
    endtask

    function automatic logic [31:0] rand32();
        rand32 = $random(seed);
    endfunction

    function automatic reg_code_t map_code(input logic [7:0] code, input logic [1:0] cur);
        reg_code_t c;
        c = code;
        if (code[7:4] == `REGS_CODE_CUR)
            c.bank.bank = {2'b00, cur};
        else if (code[7:4] == `REGS_CODE_PREV)
            c.bank.bank = {2'b00, cur - 2'd1};
        return c;
    endfunction

    // model slot of one lane of the aligned long named by a code
    function automatic int byte_slot(input reg_code_t c, input int lane);
        if (c.ptr.flag)
            return 64 + int'(c.ptr.num) * 4 + lane;
        return int'(c.bank.bank[1:0]) * 16 + int'(c.bank.idx[3:2]) * 4 + lane;
    endfunction

    // reference model: expected long word read through a code
    function automatic logic [31:0] expect_long(input logic [7:0] code, input bit is_src);
        reg_code_t   a;
        logic [31:0] v;
        a = map_code(code, model_rfp);
        if (is_src && code[7:4] == `REGS_CODE_ZERO)
            return 32'd0;
        for (int i = 0; i < 4; i++)
            v[8*i +: 8] = model_mem[byte_slot(a, i)];
        return v;
    endfunction

    function automatic logic [15:0] model_bc();
        return {model_mem[int'(model_rfp) * 16 + 5], model_mem[int'(model_rfp) * 16 + 4]};
    endfunction

    function automatic logic [7:0] dump_expect(input logic [7:0] addr);
        if (addr <= 8'h4f)
            return model_mem[int'(addr)];
        if (addr == `REGS_DMP_SR_HI)
            return sr[15:8];
        if (addr == `REGS_DMP_SR_LO)
            return sr[7:0];
        return 8'd0;
    endfunction

    // state change at a rising edge, all from pre-edge values
    task automatic apply_edge_model();
        reg_code_t   sa, da;
        logic [31:0] step_amt, step_v, xsp_v, din;
        logic [15:0] bc_v;
        logic [2:0]  mask;
        logic [1:0]  next_rfp;
        if (cen) begin
            sa = map_code(src, model_rfp);
            da = map_code(dst, model_rfp);
            step_amt = reg_step == 2'd1 ? 32'd2 : (reg_step == 2'd2 ? 32'd4 : 32'd1);
            step_v = reg_dec ? expect_long(src, 1) - step_amt : expect_long(src, 1) + step_amt;
            bc_v = model_bc() - 16'd1;
            xsp_v = {model_mem[79], model_mem[78], model_mem[77], model_mem[76]};
            if (inc_xsp != 16'd0)
                xsp_v = xsp_v + {16'd0, inc_xsp};
            else if (dec_xsp != 16'd0)
                xsp_v = xsp_v - {16'd0, dec_xsp};
            next_rfp = rfp_we ? imm : (dec_rfp ? model_rfp - 2'd1 :
                       (inc_rfp ? model_rfp + 2'd1 : model_rfp));
            din = data_sel ? ram_dout : alu_dout;
            mask = flag_only ? 3'd0 : (data_sel ? ram_we : alu_we);

            if ((reg_inc || reg_dec) && src[7:4] != `REGS_CODE_ZERO)
                for (int i = 0; i < 4; i++)
                    model_mem[byte_slot(sa, i)] = step_v[8*i +: 8];
            if (dec_bc) begin
                model_mem[int'(model_rfp) * 16 + 4] = bc_v[7:0];
                model_mem[int'(model_rfp) * 16 + 5] = bc_v[15:8];
            end
            // zero amounts leave XSP alone, so a step on it survives
            if (inc_xsp != 16'd0 || dec_xsp != 16'd0)
                for (int i = 0; i < 4; i++)
                    model_mem[76 + i] = xsp_v[8*i +: 8];
            if (mask[2]) begin
                for (int i = 0; i < 4; i++)
                    model_mem[byte_slot(da, i)] = din[8*i +: 8];
            end else if (mask[1]) begin
                model_mem[byte_slot(da, dst[1] ? 2 : 0)] = din[7:0];
                model_mem[byte_slot(da, dst[1] ? 3 : 1)] = din[15:8];
            end else if (mask[0]) begin
                model_mem[byte_slot(da, int'(dst[1:0]))] = din[7:0];
            end
            model_rfp = next_rfp;
        end
    endtask

    // comparing process, halfway between driving edges
    always @(negedge clk) begin
        if (rst) begin
            exp_dmp = 8'd0;
            exp_bcu = 1'b0;
        end else begin
            check_value("src_out", src_out, expect_long(src, 1));
            check_value("dst_out", dst_out, expect_long(dst, 0));
            check_value("xsp", xsp, {model_mem[79], model_mem[78], model_mem[77], model_mem[76]});
            check_value("rfp", {30'd0, rfp}, {30'd0, model_rfp});
            check_value("dmp_dout", {24'd0, dmp_dout}, {24'd0, exp_dmp});
            check_value("bc_unity", {31'd0, bc_unity}, {31'd0, exp_bcu});
            exp_dmp = dump_expect(dmp_addr);
            if (cen)
                exp_bcu = model_bc() == 16'd1;
        end
    end

    task automatic clear_strobes();
        {inc_rfp, dec_rfp, rfp_we, flag_only, reg_inc, reg_dec, dec_bc} = 7'd0;
        alu_we = 3'd0;
        ram_we = 3'd0;
        inc_xsp = 16'd0;
        dec_xsp = 16'd0;
    endtask

    task automatic cycle();
        @(posedge clk);
        apply_edge_model();
        #5;
        clear_strobes();
    endtask

    function automatic logic [7:0] pick_code();
        logic [31:0] r;
        r = rand32();
        case (r[1:0])
            2'd0: return {2'b00, r[9:8], r[15:12]};
            2'd1: return {`REGS_CODE_CUR, r[15:12]};
            2'd2: return {`REGS_CODE_PREV, r[15:12]};
            default: return {4'h8, r[11:10], r[13:12]};
        endcase
    endfunction

    task automatic write_reg(input logic [7:0] code, input logic [31:0] data,
                             input logic [2:0] width, input logic use_ram);
        dst = code;
        data_sel = use_ram;
        alu_dout = use_ram ? rand32() : data;
        ram_dout = use_ram ? data : rand32();
        if (use_ram)
            ram_we = width;
        else
            alu_we = width;
        cycle();
    endtask

    initial begin
        logic [31:0] r;
        bit          seen;
        seed = 32'h2b13_f45a;
        err_count = 0;
        clk = 1'b0;
        rst = 1'b1;
        cen = 1'b1;
        clear_strobes();
        {imm, reg_step, data_sel} = 5'd0;
        {src, dst, dmp_addr} = 24'd0;
        {alu_dout, ram_dout} = 64'd0;
        sr = 16'h0;
        model_rfp = 2'd0;
        for (int i = 0; i < 80; i++)
            model_mem[i] = 8'd0;
        for (int i = 0; i < 4; i++)
            model_mem[76 + i] = 8'(`REGS_XSP_RESET >> (8 * i));
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;

        // dump sweep of the reset state
        r = rand32();
        sr = r[15:0];
        check_value("xsp after reset", xsp, `REGS_XSP_RESET);
        for (int a = 0; a <= 8'h51; a++) begin
            dmp_addr = 8'(a);
            cycle();
        end
        cycle();

        // random writes through both paths, some flag-only
        repeat (80) begin
            r = rand32();
            flag_only = r[4:2] == 3'd0;
            src = pick_code();
            dmp_addr = {1'b0, r[22:16]};
            write_reg(pick_code(), rand32(), 3'd1 << (r[31:30] % 2'd3), r[5]);
            src = dst;
            cycle();
        end

        // bank pointer load, step and wrap of previous bank
        rfp_we = 1'b1;
        imm = 2'd2;
        cycle();
        inc_rfp = 1'b1;
        cycle();
        dec_rfp = 1'b1;
        inc_rfp = 1'b1;
        cycle();
        rfp_we = 1'b1;
        imm = 2'd0;
        dec_rfp = 1'b1;
        cycle();
        write_reg(8'hd4, 32'h3a5c_7e91, 3'd4, 1'b0);
        write_reg(8'he8, 32'h0000_1234, 3'd2, 1'b1);
        write_reg(8'h2d, 32'h0000_00c3, 3'd1, 1'b0);
        src = 8'h34;
        dst = 8'h08;
        cycle();
        check_value("bank 3 XBC", src_out, 32'h3a5c_7e91);
        check_value("bank 0 XDE", {16'd0, dst_out[15:0]}, 32'h0000_1234);
        src = 8'h2c;
        cycle();
        check_value("bank 2 XHL byte", {24'd0, src_out[15:8]}, 32'h0000_00c3);

        // source stepping, including the zero bank
        repeat (40) begin
            r = rand32();
            src = r[7:6] == 2'd0 ? {`REGS_CODE_ZERO, r[11:8]} : pick_code();
            reg_inc = r[12];
            reg_dec = !r[12];
            reg_step = r[14:13];
            dmp_addr = {1'b0, r[22:16]};
            cycle();
        end
        src = 8'h45;
        cycle();
        check_value("zero bank src_out", src_out, 32'd0);

        // stack adjust and the BC unity flag
        r = rand32();
        inc_xsp = r[15:0];
        cycle();
        dec_xsp = r[31:16];
        cycle();
        inc_xsp = 16'h0010;
        dec_xsp = 16'h0004;
        cycle();
        write_reg(8'he4, 32'h0000_0002, 3'd4, 1'b0);
        dec_bc = 1'b1;
        cycle();
        seen = 1'b0;
        for (int n = 0; n < 4 && !seen; n++) begin
            cycle();
            seen = bc_unity;
        end
        if (!seen)
            report_problem("bc_unity did not rise after BC reached one");

        // frozen state with cen low
        cen = 1'b0;
        repeat (6) begin
            r = rand32();
            {inc_rfp, dec_rfp, rfp_we, reg_inc, reg_dec, dec_bc} = r[5:0];
            alu_we = 3'd4;
            inc_xsp = r[31:16];
            dst = pick_code();
            src = pick_code();
            dmp_addr = {1'b0, r[14:8]};
            cycle();
        end
        cen = 1'b1;
        repeat (2) cycle();

        if (err_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    initial begin
        #2_000_000;
        report_problem("simulation ran past its time limit");
    end

endmodule

/* verilog.f */
+incdir+common
common/regs_pkg.sv
regs/reg_code_map.sv
regs/reg_file.sv
verilog/regs_top.sv
test/regs_props.sv
test/regs_tb.sv

/* verilog/regs_top.sv */
// register file top level
// the code mapper resolves bank-relative codes, the storage
// block holds the registers and serves all ports
`timescale 1ns/1ns

module regs_top import regs_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    // bank pointer control
    input  logic        inc_rfp,
    input  logic        dec_rfp,
    input  logic        rfp_we,
    input  logic [ 1:0] imm,
    output logic [ 1:0] rfp,
    // operand codes
    input  logic [ 7:0] src,
    input  logic [ 7:0] dst,
    // write path
    input  logic [31:0] alu_dout,
    input  logic [31:0] ram_dout,
    input  logic        data_sel,
    input  logic [ 2:0] alu_we,
    input  logic [ 2:0] ram_we,
    input  logic        flag_only,
    // stepping and stack
    input  logic        reg_inc,
    input  logic        reg_dec,
    input  logic [ 1:0] reg_step,
    input  logic [15:0] inc_xsp,
    input  logic [15:0] dec_xsp,
    input  logic        dec_bc,
    // status and dump
    input  logic [15:0] sr,
    input  logic [ 7:0] dmp_addr,
    output logic [31:0] src_out,
    output logic [31:0] dst_out,
    output logic [31:0] xsp,
    output logic        bc_unity,
    output logic [ 7:0] dmp_dout
);

    reg_code_t src_abs;
    reg_code_t dst_abs;

    reg_code_map code_map_inst (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .inc_rfp (inc_rfp),
        .dec_rfp (dec_rfp),
        .rfp_we  (rfp_we),
        .imm     (imm),
        .src     (src),
        .dst     (dst),
        .rfp     (rfp),
        .src_abs (src_abs),
        .dst_abs (dst_abs)
    );

    reg_file file_inst (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .rfp       (rfp),
        .src_abs   (src_abs),
        .dst_abs   (dst_abs),
        .alu_dout  (alu_dout),
        .ram_dout  (ram_dout),
        .data_sel  (data_sel),
        .alu_we    (alu_we),
        .ram_we    (ram_we),
        .flag_only (flag_only),
        .reg_inc   (reg_inc),
        .reg_dec   (reg_dec),
        .reg_step  (reg_step),
        .inc_xsp   (inc_xsp),
        .dec_xsp   (dec_xsp),
        .dec_bc    (dec_bc),
        .sr        (sr),
        .dmp_addr  (dmp_addr),
        .src_out   (src_out),
        .dst_out   (dst_out),
        .xsp       (xsp),
        .bc_unity  (bc_unity),
        .dmp_dout  (dmp_dout)
    );

endmodule
